//--- design/csi_rx_pkg.sv
`default_nettype none

package csi_rx_pkg;

   // one header word, read either as a long or as a short packet header
   typedef union packed {
      struct packed {
         logic [7:0]  ecc;         // not checked
         logic [15:0] word_count;  // payload length in bytes
         logic [7:0]  data_id;     // vc in 7:6, type in 5:0
      } long_view;
      struct packed {
         logic [7:0]  ecc;
         logic [15:0] short_data;  // frame or line number
         logic [7:0]  data_id;
      } short_view;
   } csi_header_t;

   // synchronisation short packet types
   localparam logic [5:0] dt_frame_start = 6'h00;
   localparam logic [5:0] dt_frame_end   = 6'h01;
   localparam logic [5:0] dt_line_start  = 6'h02;
   localparam logic [5:0] dt_line_end    = 6'h03;

   // the only long packet type that is unpacked
   localparam logic [5:0] dt_raw10 = 6'h2B;

   // types up to here carry no payload
   localparam logic [5:0] dt_short_max = 6'h0F;

   // crc-16 ccitt, processed lsb first, no final xor
   localparam logic [15:0] crc_init = 16'hFFFF;
   localparam logic [15:0] crc_poly = 16'h8408;  // reflected x^16+x^12+x^5+1

   // pixel output format
   localparam int pixel_width     = 10;
   localparam int pixels_per_word = 4;

endpackage

`default_nettype wire

//--- design/csi_rx_header_decode.sv
`timescale 1ns/1ps
`default_nettype none

module csi_rx_header_decode (
   input  wire  [31:0] header,           // first word of a packet
   output logic        is_short,         // no payload follows
   output logic [5:0]  data_type,
   output logic [1:0]  virtual_channel,
   output logic [15:0] word_count,       // long packet view of the 16-bit field
   output logic [15:0] short_data        // short packet view of the same field
);

   csi_rx_pkg::csi_header_t hdr;

   assign hdr = header;

   // the data id sits in the same place in both views
   assign data_type       = hdr.long_view.data_id[5:0];
   assign virtual_channel = hdr.long_view.data_id[7:6];

   // short packets occupy the low end of the type space
   assign is_short = (hdr.long_view.data_id[5:0] <= csi_rx_pkg::dt_short_max);

   assign word_count = hdr.long_view.word_count;    // bytes of payload
   assign short_data = hdr.short_view.short_data;   // frame or line number

endmodule

`default_nettype wire

//--- design/csi_rx_packet_handler.sv
`timescale 1ns/1ps
`default_nettype none

module csi_rx_packet_handler #(
   parameter logic [1:0] virtual_channel_sel = 2'd0
) (
   input  wire         clock,
   input  wire         reset,
   input  wire         enable,           // headers are dropped while low
   input  wire  [31:0] word_in,
   input  wire         word_valid,       // high for every word of a packet

   input  wire         is_short,         // from the header decoder
   input  wire  [5:0]  data_type,
   input  wire  [1:0]  virtual_channel,
   input  wire  [15:0] word_count,
   input  wire  [15:0] short_data,

   output logic [31:0] header,           // word under test by the decoder
   output logic [31:0] payload,
   output logic        payload_valid,
   output logic        payload_first,    // first payload word of a packet
   output logic        raw10_valid,      // payload_valid for raw10 packets only
   output logic        footer_valid,
   output logic [15:0] footer_crc,

   output logic        frame_start,
   output logic        frame_end,
   output logic        line_start,
   output logic        line_end,
   output logic [15:0] sync_number
);

   localparam logic [1:0] st_idle    = 2'd0;  // waiting for a header
   localparam logic [1:0] st_payload = 2'd1;
   localparam logic [1:0] st_footer  = 2'd2;
   localparam logic [1:0] st_skip    = 2'd3;  // ignore words until the gap

   logic [1:0]  state;
   logic [13:0] words_left;   // payload words still to come
   logic        first_word;
   logic        is_raw10;
   logic        accept;
   logic        take_payload;
   logic        take_footer;
   logic        take_short;

   // the decoder always looks at the incoming word, only idle uses the result
   assign header = word_in;

   assign accept       = enable && (virtual_channel == virtual_channel_sel);
   assign take_payload = (state == st_payload) && word_valid;
   assign take_footer  = (state == st_footer) && word_valid;
   assign take_short   = (state == st_idle) && word_valid && accept && is_short;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state         <= st_idle;
         words_left    <= '0;
         first_word    <= 1'b0;
         is_raw10      <= 1'b0;
         payload_valid <= 1'b0;
         payload_first <= 1'b0;
         raw10_valid   <= 1'b0;
         footer_valid  <= 1'b0;
         frame_start   <= 1'b0;
         frame_end     <= 1'b0;
         line_start    <= 1'b0;
         line_end      <= 1'b0;
      end else begin
         payload_valid <= 1'b0;  // all outputs are single-cycle pulses
         payload_first <= 1'b0;
         raw10_valid   <= 1'b0;
         footer_valid  <= 1'b0;
         frame_start   <= 1'b0;
         frame_end     <= 1'b0;
         line_start    <= 1'b0;
         line_end      <= 1'b0;

         case (state)
            st_idle: begin
               if (word_valid) begin
                  if (!accept) begin
                     state <= st_skip;  // other channel or disabled
                  end else if (is_short) begin
                     frame_start <= (data_type == csi_rx_pkg::dt_frame_start);
                     frame_end   <= (data_type == csi_rx_pkg::dt_frame_end);
                     line_start  <= (data_type == csi_rx_pkg::dt_line_start);
                     line_end    <= (data_type == csi_rx_pkg::dt_line_end);
                     state       <= st_skip;
                  end else begin
                     words_left <= word_count[15:2];  // bytes to words
                     first_word <= 1'b1;
                     is_raw10   <= (data_type == csi_rx_pkg::dt_raw10);
                     state      <= (word_count[15:2] == 14'd0) ? st_footer : st_payload;
                  end
               end
            end
            st_payload: begin
               if (!word_valid) begin
                  state <= st_idle;  // packet cut short
               end else begin
                  payload_valid <= 1'b1;
                  payload_first <= first_word;
                  raw10_valid   <= is_raw10;
                  first_word    <= 1'b0;
                  words_left    <= words_left - 14'd1;
                  if (words_left == 14'd1) begin
                     state <= st_footer;
                  end
               end
            end
            st_footer: begin
               if (!word_valid) begin
                  state <= st_idle;
               end else begin
                  footer_valid <= 1'b1;
                  state        <= st_skip;
               end
            end
            default: begin
               if (!word_valid) begin
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (take_payload) begin
         payload <= word_in;
      end
      if (take_footer) begin
         footer_crc <= word_in[15:0];  // upper half of the footer is unused
      end
      if (take_short) begin
         sync_number <= short_data;
      end
   end

endmodule

`default_nettype wire

//--- design/csi_rx_crc16.sv
`timescale 1ns/1ps
`default_nettype none

module csi_rx_crc16 (
   input  wire         clock,
   input  wire         reset,
   input  wire  [31:0] payload,        // byte 0 in bits 7:0
   input  wire         payload_valid,
   input  wire         payload_first,  // restart the running crc
   input  wire         footer_valid,
   input  wire  [15:0] footer_crc,
   output logic        crc_ok,
   output logic        crc_error
);

   logic [15:0] crc_reg;
   logic [15:0] crc_seed;
   logic [15:0] crc_next;

   // one byte through the reflected crc, lsb first
   function automatic logic [15:0] crc_byte(input logic [15:0] crc_in,
                                            input logic [7:0]  data);
      logic [15:0] crc;
      integer      bit_idx;
      crc = crc_in ^ {8'h00, data};
      for (bit_idx = 0; bit_idx < 8; bit_idx = bit_idx + 1) begin
         if (crc[0]) begin
            crc = (crc >> 1) ^ csi_rx_pkg::crc_poly;
         end else begin
            crc = crc >> 1;
         end
      end
      return crc;
   endfunction

   // four bytes per cycle in stream order
   function automatic logic [15:0] crc_word(input logic [15:0] crc_in,
                                            input logic [31:0] data);
      logic [15:0] crc;
      integer      byte_idx;
      crc = crc_in;
      for (byte_idx = 0; byte_idx < 4; byte_idx = byte_idx + 1) begin
         crc = crc_byte(crc, data[byte_idx*8 +: 8]);
      end
      return crc;
   endfunction

   assign crc_seed = payload_first ? csi_rx_pkg::crc_init : crc_reg;
   assign crc_next = crc_word(crc_seed, payload);

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         crc_reg   <= csi_rx_pkg::crc_init;
         crc_ok    <= 1'b0;
         crc_error <= 1'b0;
      end else begin
         crc_ok    <= footer_valid && (crc_reg == footer_crc);
         crc_error <= footer_valid && (crc_reg != footer_crc);
         if (payload_valid) begin
            crc_reg <= crc_next;
         end else if (footer_valid) begin
            crc_reg <= csi_rx_pkg::crc_init;  // ready for an empty packet
         end
      end
   end

endmodule

`default_nettype wire

//--- design/csi_rx_10bit_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module csi_rx_10bit_unpack (
   input  wire         clock,
   input  wire         reset,
   input  wire         enable,      // freezes the whole pipeline when low
   input  wire  [31:0] data_in,     // raw10 payload, byte 0 in bits 7:0
   input  wire         din_valid,
   output logic [39:0] data_out,    // pixel 0 in bits 9:0
   output logic        dout_valid
);

   logic [31:0] byte_buf;        // bytes left over from the last word
   logic [2:0]  byte_count;      // 0 to 4 bytes held in byte_buf
   logic [39:0] group;           // five packed bytes
   logic        group_valid;
   logic [39:0] unpacked;
   logic        unpacked_valid;

   // bytes 0..3 carry the high bits, byte 4 the low two bits of each pixel
   function automatic logic [39:0] unpack_raw10(input logic [39:0] grp);
      logic [39:0] pix;
      integer      p;
      for (p = 0; p < csi_rx_pkg::pixels_per_word; p = p + 1) begin
         pix[p*csi_rx_pkg::pixel_width +: csi_rx_pkg::pixel_width] =
            {grp[p*8 +: 8], grp[32 + 2*p +: 2]};
      end
      return pix;
   endfunction

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         byte_count     <= 3'd0;
         group_valid    <= 1'b0;
         unpacked_valid <= 1'b0;
         dout_valid     <= 1'b0;
      end else if (enable) begin
         if (!din_valid) begin
            byte_count  <= 3'd0;  // no bytes carry over between packets
            group_valid <= 1'b0;
         end else begin
            group_valid <= (byte_count != 3'd0);  // an empty buffer cannot complete a group
            byte_count  <= (byte_count == 3'd0) ? 3'd4 : byte_count - 3'd1;
         end
         unpacked_valid <= group_valid;
         dout_valid     <= unpacked_valid;
      end
   end

   always_ff @(posedge clock) begin
      if (enable) begin
         if (din_valid) begin
            case (byte_count)
               3'd0: begin
                  byte_buf <= data_in;  // whole word waits for one more byte
               end
               3'd4: begin
                  group    <= {data_in[7:0], byte_buf};
                  byte_buf <= {8'h00, data_in[31:8]};
               end
               3'd3: begin
                  group    <= {data_in[15:0], byte_buf[23:0]};
                  byte_buf <= {16'h0000, data_in[31:16]};
               end
               3'd2: begin
                  group    <= {data_in[23:0], byte_buf[15:0]};
                  byte_buf <= {24'h000000, data_in[31:24]};
               end
               default: begin
                  group <= {data_in, byte_buf[7:0]};  // buffer drains fully
               end
            endcase
         end
         unpacked <= unpack_raw10(group);
         data_out <= unpacked;
      end
   end

endmodule

`default_nettype wire

//--- design/csi_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module csi_rx_top #(
   parameter logic [1:0] virtual_channel_sel = 2'd0  // channel to accept
) (
   input  wire         clock,
   input  wire         reset,
   input  wire         enable,
   input  wire  [31:0] word_in,      // merged lane data, 4 bytes per cycle
   input  wire         word_valid,
   output logic [39:0] pixels,
   output logic        pixel_valid,
   output logic        frame_start,
   output logic        frame_end,
   output logic        line_start,
   output logic        line_end,
   output logic [15:0] sync_number,
   output logic        crc_ok,
   output logic        crc_error
);

   logic [31:0] header;
   logic        is_short;
   logic [5:0]  data_type;
   logic [1:0]  virtual_channel;
   logic [15:0] word_count;
   logic [15:0] short_data;
   logic [31:0] payload;
   logic        payload_valid;
   logic        payload_first;
   logic        raw10_valid;
   logic        footer_valid;
   logic [15:0] footer_crc;

   csi_rx_header_decode u_header_decode (
      .header          (header),
      .is_short        (is_short),
      .data_type       (data_type),
      .virtual_channel (virtual_channel),
      .word_count      (word_count),
      .short_data      (short_data)
   );

   csi_rx_packet_handler #(
      .virtual_channel_sel (virtual_channel_sel)
   ) u_packet_handler (
      .clock           (clock),
      .reset           (reset),
      .enable          (enable),
      .word_in         (word_in),
      .word_valid      (word_valid),
      .is_short        (is_short),
      .data_type       (data_type),
      .virtual_channel (virtual_channel),
      .word_count      (word_count),
      .short_data      (short_data),
      .header          (header),
      .payload         (payload),
      .payload_valid   (payload_valid),
      .payload_first   (payload_first),
      .raw10_valid     (raw10_valid),
      .footer_valid    (footer_valid),
      .footer_crc      (footer_crc),
      .frame_start     (frame_start),
      .frame_end       (frame_end),
      .line_start      (line_start),
      .line_end        (line_end),
      .sync_number     (sync_number)
   );

   csi_rx_crc16 u_crc16 (
      .clock         (clock),
      .reset         (reset),
      .payload       (payload),
      .payload_valid (payload_valid),  // every long packet is checked
      .payload_first (payload_first),
      .footer_valid  (footer_valid),
      .footer_crc    (footer_crc),
      .crc_ok        (crc_ok),
      .crc_error     (crc_error)
   );

   csi_rx_10bit_unpack u_10bit_unpack (
      .clock      (clock),
      .reset      (reset),
      .enable     (enable),
      .data_in    (payload),
      .din_valid  (raw10_valid),  // only raw10 payload reaches the unpacker
      .data_out   (pixels),
      .dout_valid (pixel_valid)
   );

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
   parameter int period_ns = 40
) (
   output logic clock
);

   initial begin
      clock = 1'b0;
      forever #(period_ns / 2) clock = ~clock;  // 50% duty cycle
   end

endmodule

`default_nettype wire

//--- tests/csi_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csi_rx_tb;

   localparam logic [1:0] our_vc     = 2'd1;
   localparam int         max_cycles = 4000;  // well above the length of the stimulus

   logic        clock;
   logic        reset;
   logic        enable;
   logic [31:0] word_in;
   logic        word_valid;
   logic [39:0] pixels;
   logic        pixel_valid;
   logic        frame_start;
   logic        frame_end;
   logic        line_start;
   logic        line_end;
   logic [15:0] sync_number;
   logic        crc_ok;
   logic        crc_error;

   int          cycle = 0;
   logic [39:0] exp_pixels[$];
   int          exp_pixel_cycle[$];
   int          exp_event_kind[$];    // 0..3 sync type, 4 crc ok, 5 crc error
   logic [15:0] exp_event_number[$];
   int          exp_event_cycle[$];
   logic [7:0]  pkt_bytes[$];         // payload of the packet being built
   int          line;
   logic [15:0] frame_no;

   clock_gen #(.period_ns(40)) u_clock_gen (.clock(clock));

   csi_rx_top #(.virtual_channel_sel(our_vc)) uut (
      .clock       (clock),
      .reset       (reset),
      .enable      (enable),
      .word_in     (word_in),
      .word_valid  (word_valid),
      .pixels      (pixels),
      .pixel_valid (pixel_valid),
      .frame_start (frame_start),
      .frame_end   (frame_end),
      .line_start  (line_start),
      .line_end    (line_end),
      .sync_number (sync_number),
      .crc_ok      (crc_ok),
      .crc_error   (crc_error)
   );

   task automatic fail_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
      $display("FAILED %s got %h expected %h at cycle %0d", name, got, expected, cycle);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic drive(input logic [31:0] data, input logic valid);
      @(posedge clock);
      #5;
      word_in    = data;
      word_valid = valid;
   endtask

   task automatic idle(input int n);
      repeat (n) drive($urandom, 1'b0);  // junk on the bus between packets
   endtask

   function automatic logic [31:0] make_header(input logic [1:0] vc, input logic [5:0] dt,
                                               input logic [15:0] field);
      csi_rx_pkg::csi_header_t hdr;
      hdr.long_view.data_id    = {vc, dt};
      hdr.long_view.word_count = field;
      hdr.long_view.ecc        = 8'($urandom);  // receiver ignores it
      return hdr;
   endfunction

   // bitwise reference with feedback from lsb of crc xor data bit
   function automatic logic [15:0] crc_of_payload();
      logic [15:0] crc;
      logic        feedback;
      int          i;
      int          b;
      crc = 16'hFFFF;
      for (i = 0; i < pkt_bytes.size(); i++) begin
         for (b = 0; b < 8; b++) begin
            feedback = crc[0] ^ pkt_bytes[i][b];
            crc      = {1'b0, crc[15:1]};
            if (feedback) begin
               crc = crc ^ 16'h8408;
            end
         end
      end
      return crc;
   endfunction

   task automatic send_short(input logic [1:0] vc, input logic [5:0] dt,
                             input logic [15:0] number, input int gap);
      drive(make_header(vc, dt, number), 1'b1);
      if (vc == our_vc && enable) begin
         exp_event_kind.push_back(int'(dt));
         exp_event_number.push_back(number);
         exp_event_cycle.push_back(cycle + 1);
      end
      idle(gap);
   endtask

   task automatic send_raw10(input logic [1:0] vc, input int n_bytes,
                             input logic [15:0] flip_mask, input int gap);
      logic [9:0]  pix[0:3];
      logic        accepted;
      int          first_cycle;
      int          g;
      int          p;
      int          k;
      accepted = (vc == our_vc) && enable;
      pkt_bytes.delete();
      for (g = 0; g < n_bytes / 5; g++) begin
         for (p = 0; p < 4; p++) begin
            pix[p] = 10'($urandom);
            pkt_bytes.push_back(pix[p][9:2]);
         end
         pkt_bytes.push_back({pix[3][1:0], pix[2][1:0], pix[1][1:0], pix[0][1:0]});
         if (accepted) begin
            exp_pixels.push_back({pix[3], pix[2], pix[1], pix[0]});
         end
      end
      drive(make_header(vc, csi_rx_pkg::dt_raw10, 16'(n_bytes)), 1'b1);
      first_cycle = cycle + 1;
      // group g ends in payload word (5g+4)/4 and shows up 4 cycles later
      if (accepted) begin
         for (g = 0; g < n_bytes / 5; g++) begin
            exp_pixel_cycle.push_back(first_cycle + (5 * g + 4) / 4 + 4);
         end
      end
      for (k = 0; k < n_bytes / 4; k++) begin
         drive({pkt_bytes[4*k+3], pkt_bytes[4*k+2], pkt_bytes[4*k+1], pkt_bytes[4*k]}, 1'b1);
      end
      drive({16'($urandom), crc_of_payload() ^ flip_mask}, 1'b1);
      if (accepted) begin
         exp_event_kind.push_back((flip_mask != 16'h0) ? 5 : 4);
         exp_event_number.push_back(16'h0);
         exp_event_cycle.push_back(cycle + 2);
      end
      idle(gap);
   endtask

   always @(posedge clock) begin
      cycle <= cycle + 1;
      if (cycle >= max_cycles) begin
         $display("timeout: expected outputs never arrived within %0d cycles", max_cycles);
         $display("sim failed");
         $fatal(1);
      end
   end

   // outputs are sampled mid-cycle away from the rising edge
   always @(negedge clock) begin : check_outputs
      logic [5:0] got_events;
      logic [5:0] exp_events;
      logic       exp_pixel;
      got_events = {crc_error, crc_ok, line_end, line_start, frame_end, frame_start};
      exp_events = 6'd0;
      if (exp_event_cycle.size() > 0 && exp_event_cycle[0] == cycle) begin
         exp_events = 6'(1 << exp_event_kind[0]);
      end
      assert (got_events === exp_events)
         else fail_value("{crc_error,crc_ok,line_end,line_start,frame_end,frame_start}",
                         {58'd0, got_events}, {58'd0, exp_events});
      if (exp_events != 6'd0) begin
         if (exp_event_kind[0] < 4) begin
            assert (sync_number === exp_event_number[0])
               else fail_value("sync_number", {48'd0, sync_number}, {48'd0, exp_event_number[0]});
         end
         void'(exp_event_kind.pop_front());
         void'(exp_event_number.pop_front());
         void'(exp_event_cycle.pop_front());
      end
      exp_pixel = (exp_pixel_cycle.size() > 0) && (exp_pixel_cycle[0] == cycle);
      assert (pixel_valid === exp_pixel)
         else fail_value("pixel_valid", {63'd0, pixel_valid}, {63'd0, exp_pixel});
      if (exp_pixel) begin
         assert (pixels === exp_pixels[0])
            else fail_value("pixels", {24'd0, pixels}, {24'd0, exp_pixels[0]});
         void'(exp_pixels.pop_front());
         void'(exp_pixel_cycle.pop_front());
      end
   end

   initial begin
      void'($urandom(32'h8181e0cf));
      reset      = 1'b1;
      enable     = 1'b1;
      word_in    = 32'h0;
      word_valid = 1'b0;
      repeat (2) @(posedge clock);
      #5;
      reset = 1'b0;
      idle(6);  // quiet after reset so no pulse may show up

      // one frame of three lines with growing payloads
      frame_no = 16'($urandom);
      send_short(our_vc, csi_rx_pkg::dt_frame_start, frame_no, 2);
      for (line = 1; line <= 3; line++) begin
         send_short(our_vc, csi_rx_pkg::dt_line_start, 16'(line), 2);
         send_raw10(our_vc, (line == 1) ? 20 : ((line == 2) ? 40 : 100), 16'h0, 3);
         send_short(our_vc, csi_rx_pkg::dt_line_end, 16'(line), 2);
      end
      send_short(our_vc, csi_rx_pkg::dt_frame_end, frame_no, 4);

      // good footer followed by one with a single bit flipped
      send_raw10(our_vc, 40, 16'h0, 2);
      send_raw10(our_vc, 40, 16'(1 << ($urandom % 16)), 3);

      // wrong channel
      send_raw10(2'd2, 40, 16'h0, 2);
      send_short(2'd2, csi_rx_pkg::dt_frame_start, 16'h1234, 2);

      // receiver disabled for the whole packet
      enable = 1'b0;
      send_raw10(our_vc, 40, 16'h0, 2);
      send_short(our_vc, csi_rx_pkg::dt_line_start, 16'h0007, 2);
      enable = 1'b1;

      // back to back with a single idle cycle between packets
      send_raw10(our_vc, 20, 16'h0, 1);
      send_raw10(our_vc, 40, 16'h0, 1);
      send_raw10(our_vc, 100, 16'h0, 1);

      while (exp_pixels.size() != 0 || exp_event_kind.size() != 0) begin
         @(posedge clock);
      end
      idle(8);  // any stray pulse in the tail still trips the checker

      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
design/csi_rx_pkg.sv
design/csi_rx_header_decode.sv
design/csi_rx_packet_handler.sv
design/csi_rx_crc16.sv
design/csi_rx_10bit_unpack.sv
design/csi_rx_top.sv
tests/clock_gen.sv
tests/csi_rx_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run; passes only if the simulation prints the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --timing --assert --top-module csi_rx_tb \
   -f flist.f -o csi_rx_sim || exit 1

out=$(./obj_dir/csi_rx_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "sim passed" && echo "PASS" || { echo "FAIL"; exit 1; }
